//--- rtl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    localparam int xlen = 64;

    localparam logic [63:0] reset_pc = 64'h8000_0000; // pc of the first accepted word

    // major opcodes
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_pass_b = 4'd7   // lui result
    } alu_op_t;

    // ----------------------------------------
    // instruction views
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;         // operand addresses
        inst_i_t i;         // immediates
    } inst_u;

    // decoded control, decode to execute
    typedef struct packed {
        alu_op_t    alu_op;
        logic       b_is_imm;
        logic       reg_wen;
        logic       illegal;
        logic [4:0] rd;
    } de_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// one stage-to-stage transfer with valid/allowin handshake
interface stage_if;

    logic                          valid;
    logic                          allowin;
    logic [63:0]                   pc;
    rv_pipe_pkg::de_ctrl_t         ctrl;
    logic [rv_pipe_pkg::xlen-1:0]  src1;
    logic [rv_pipe_pkg::xlen-1:0]  src2;
    logic [rv_pipe_pkg::xlen-1:0]  imm;    // low word holds the raw inst on f2d

    modport sender (
        output valid, pc, ctrl, src1, src2, imm,
        input  allowin
    );

    modport receiver (
        input  valid, pc, ctrl, src1, src2, imm,
        output allowin
    );

endinterface

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        in_valid_i,
    input  wire logic [31:0] in_inst_i,
    output logic             in_ready_o,
    stage_if.sender          out
);

    logic        fs_valid;
    logic [31:0] fs_inst;
    logic [63:0] fs_pc;
    logic [63:0] next_pc;   // pc for the next accepted word

    assign in_ready_o = !fs_valid || out.allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
            next_pc  <= rv_pipe_pkg::reset_pc;
        end else if (in_ready_o) begin
            fs_valid <= in_valid_i;
            if (in_valid_i) begin
                next_pc <= next_pc + 64'd4;
            end
        end
        if (in_valid_i && in_ready_o) begin
            fs_inst <= in_inst_i;
            fs_pc   <= next_pc;
        end
    end

    // only pc and the raw word are meaningful here
    assign out.valid = fs_valid;
    assign out.pc    = fs_pc;
    assign out.ctrl  = '0;
    assign out.src1  = '0;
    assign out.src2  = '0;
    assign out.imm   = {{(rv_pipe_pkg::xlen-32){1'b0}}, fs_inst};

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [4:0]                   raddr1_i,
    input  wire logic [4:0]                   raddr2_i,
    output logic      [rv_pipe_pkg::xlen-1:0] rdata1_o,
    output logic      [rv_pipe_pkg::xlen-1:0] rdata2_o,
    input  wire logic                         wen_i,
    input  wire logic [4:0]                   waddr_i,
    input  wire logic [rv_pipe_pkg::xlen-1:0] wdata_i
);

    logic [rv_pipe_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen_i && waddr_i != 5'd0) begin  // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    stage_if.receiver                         in,
    stage_if.sender                           out,
    input  wire logic                         fwd_wen_i,
    input  wire logic [4:0]                   fwd_rd_i,
    input  wire logic [rv_pipe_pkg::xlen-1:0] fwd_data_i,
    input  wire logic                         rf_wen_i,
    input  wire logic [4:0]                   rf_waddr_i,
    input  wire logic [rv_pipe_pkg::xlen-1:0] rf_wdata_i
);

    logic                         ds_valid;
    rv_pipe_pkg::inst_u           ds_inst;
    logic [63:0]                  ds_pc;
    rv_pipe_pkg::de_ctrl_t        ctrl;
    rv_pipe_pkg::alu_op_t         f3_op;
    logic                         f3_ok;
    logic [rv_pipe_pkg::xlen-1:0] rf_rdata1;
    logic [rv_pipe_pkg::xlen-1:0] rf_rdata2;
    logic [rv_pipe_pkg::xlen-1:0] imm_i;
    logic [rv_pipe_pkg::xlen-1:0] imm_u;

    // ----------------------------------------
    // pipeline register
    // ----------------------------------------
    assign in.allowin = !ds_valid || out.allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (in.allowin) begin
            ds_valid <= in.valid;
        end
        if (in.valid && in.allowin) begin
            ds_inst <= in.imm[31:0];
            ds_pc   <= in.pc;
        end
    end

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        f3_ok = 1'b1;
        case (ds_inst.r.funct3)
            3'b000:  f3_op = rv_pipe_pkg::alu_add;
            3'b010:  f3_op = rv_pipe_pkg::alu_slt;
            3'b011:  f3_op = rv_pipe_pkg::alu_sltu;
            3'b100:  f3_op = rv_pipe_pkg::alu_xor;
            3'b110:  f3_op = rv_pipe_pkg::alu_or;
            3'b111:  f3_op = rv_pipe_pkg::alu_and;
            default: begin
                f3_op = rv_pipe_pkg::alu_add;
                f3_ok = 1'b0;   // shifts not supported
            end
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = rv_pipe_pkg::alu_add;
        ctrl.rd      = ds_inst.r.rd;
        ctrl.illegal = 1'b1;
        case (ds_inst.r.opcode)
            rv_pipe_pkg::op_reg: begin
                if (ds_inst.r.funct7 == 7'b0100000 && ds_inst.r.funct3 == 3'b000) begin
                    ctrl.alu_op  = rv_pipe_pkg::alu_sub;
                    ctrl.illegal = 1'b0;
                end else if (ds_inst.r.funct7 == 7'b0000000) begin
                    ctrl.alu_op  = f3_op;
                    ctrl.illegal = !f3_ok;
                end
            end
            rv_pipe_pkg::op_imm: begin
                ctrl.alu_op   = f3_op;
                ctrl.b_is_imm = 1'b1;
                ctrl.illegal  = !f3_ok;
            end
            rv_pipe_pkg::op_lui: begin
                ctrl.alu_op   = rv_pipe_pkg::alu_pass_b;
                ctrl.b_is_imm = 1'b1;
                ctrl.illegal  = 1'b0;
            end
            default: ;
        endcase
        ctrl.reg_wen = !ctrl.illegal;
    end

    // immediates, both from the i view
    assign imm_i = {{52{ds_inst.i.imm12[11]}}, ds_inst.i.imm12};
    assign imm_u = {{32{ds_inst.i.imm12[11]}}, ds_inst.i.imm12, ds_inst.i.rs1,
                    ds_inst.i.funct3, 12'b0};

    // ----------------------------------------
    // operands with forwarding
    // ----------------------------------------
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (ds_inst.r.rs1),
        .raddr2_i (ds_inst.r.rs2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .wen_i    (rf_wen_i),
        .waddr_i  (rf_waddr_i),
        .wdata_i  (rf_wdata_i)
    );

    assign out.valid = ds_valid;
    assign out.pc    = ds_pc;
    assign out.ctrl  = ctrl;
    assign out.imm   = (ds_inst.r.opcode == rv_pipe_pkg::op_lui) ? imm_u : imm_i;
    assign out.src1  = (fwd_wen_i && fwd_rd_i != 5'd0 && fwd_rd_i == ds_inst.r.rs1) ?
                       fwd_data_i : rf_rdata1;
    assign out.src2  = (fwd_wen_i && fwd_rd_i != 5'd0 && fwd_rd_i == ds_inst.r.rs2) ?
                       fwd_data_i : rf_rdata2;

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    stage_if.receiver                         in,
    input  wire logic                         wb_ready_i,
    output logic                              wb_valid_o,
    output logic      [63:0]                  wb_pc_o,
    output logic                              wb_wen_o,
    output logic                              wb_illegal_o,
    output logic      [4:0]                   wb_rd_o,
    output logic      [rv_pipe_pkg::xlen-1:0] wb_data_o,
    output logic                              fwd_wen_o,
    output logic      [4:0]                   fwd_rd_o,
    output logic      [rv_pipe_pkg::xlen-1:0] fwd_data_o,
    output logic                              rf_wen_o,
    output logic      [4:0]                   rf_waddr_o,
    output logic      [rv_pipe_pkg::xlen-1:0] rf_wdata_o
);

    logic                         es_valid;
    logic [63:0]                  es_pc;
    rv_pipe_pkg::de_ctrl_t        es_ctrl;
    logic [rv_pipe_pkg::xlen-1:0] es_src1;
    logic [rv_pipe_pkg::xlen-1:0] es_src2;
    logic [rv_pipe_pkg::xlen-1:0] es_imm;
    logic [rv_pipe_pkg::xlen-1:0] op_b;
    logic [rv_pipe_pkg::xlen-1:0] result;

    assign in.allowin = !es_valid || wb_ready_i;   // free, or retiring now

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (in.allowin) begin
            es_valid <= in.valid;
        end
        if (in.valid && in.allowin) begin
            es_pc   <= in.pc;
            es_ctrl <= in.ctrl;
            es_src1 <= in.src1;
            es_src2 <= in.src2;
            es_imm  <= in.imm;
        end
    end

    // ----------------------------------------
    // alu
    // ----------------------------------------
    assign op_b = es_ctrl.b_is_imm ? es_imm : es_src2;

    always_comb begin
        case (es_ctrl.alu_op)
            rv_pipe_pkg::alu_add:    result = es_src1 + op_b;
            rv_pipe_pkg::alu_sub:    result = es_src1 - op_b;
            rv_pipe_pkg::alu_and:    result = es_src1 & op_b;
            rv_pipe_pkg::alu_or:     result = es_src1 | op_b;
            rv_pipe_pkg::alu_xor:    result = es_src1 ^ op_b;
            rv_pipe_pkg::alu_slt:    result = {63'b0, $signed(es_src1) < $signed(op_b)};
            rv_pipe_pkg::alu_sltu:   result = {63'b0, es_src1 < op_b};
            rv_pipe_pkg::alu_pass_b: result = op_b;
            default:                 result = '0;
        endcase
    end

    assign wb_valid_o   = es_valid;
    assign wb_pc_o      = es_pc;
    assign wb_wen_o     = es_ctrl.reg_wen;
    assign wb_illegal_o = es_ctrl.illegal;
    assign wb_rd_o      = es_ctrl.rd;
    assign wb_data_o    = result;

    assign fwd_wen_o  = es_valid && es_ctrl.reg_wen;   // result pending for decode
    assign fwd_rd_o   = es_ctrl.rd;
    assign fwd_data_o = result;

    assign rf_wen_o   = es_valid && wb_ready_i && es_ctrl.reg_wen; // only on retire
    assign rf_waddr_o = es_ctrl.rd;
    assign rf_wdata_o = result;

endmodule

`default_nettype wire

//--- rtl/rv_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_top (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         in_valid_i,
    input  wire logic [31:0]                  in_inst_i,
    output logic                              in_ready_o,
    input  wire logic                         wb_ready_i,
    output logic                              wb_valid_o,
    output logic      [63:0]                  wb_pc_o,
    output logic                              wb_wen_o,
    output logic                              wb_illegal_o,
    output logic      [4:0]                   wb_rd_o,
    output logic      [rv_pipe_pkg::xlen-1:0] wb_data_o
);

    stage_if f2d ();
    stage_if d2e ();

    // forwarding and rf write from execute back to decode
    logic                         fwd_wen;
    logic [4:0]                   fwd_rd;
    logic [rv_pipe_pkg::xlen-1:0] fwd_data;
    logic                         rf_wen;
    logic [4:0]                   rf_waddr;
    logic [rv_pipe_pkg::xlen-1:0] rf_wdata;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_inst_i  (in_inst_i),
        .in_ready_o (in_ready_o),
        .out        (f2d.sender)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .in         (f2d.receiver),
        .out        (d2e.sender),
        .fwd_wen_i  (fwd_wen),
        .fwd_rd_i   (fwd_rd),
        .fwd_data_i (fwd_data),
        .rf_wen_i   (rf_wen),
        .rf_waddr_i (rf_waddr),
        .rf_wdata_i (rf_wdata)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst          (rst),
        .in           (d2e.receiver),
        .wb_ready_i   (wb_ready_i),
        .wb_valid_o   (wb_valid_o),
        .wb_pc_o      (wb_pc_o),
        .wb_wen_o     (wb_wen_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .fwd_wen_o    (fwd_wen),
        .fwd_rd_o     (fwd_rd),
        .fwd_data_o   (fwd_data),
        .rf_wen_o     (rf_wen),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #1 rst_o = 1'b0;    // released with the other inputs
    end

endmodule

`default_nettype wire

//--- testbench/tb_wb_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_monitor #(
    parameter int case_words = 6
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        in_ready_i,
    input  wire logic        wb_valid_i,
    input  wire logic        wb_ready_i,
    input  wire logic [63:0] wb_pc_i,
    input  wire logic        wb_wen_i,
    input  wire logic        wb_illegal_i,
    input  wire logic [4:0]  wb_rd_i,
    input  wire logic [63:0] wb_data_i,
    input  wire logic [63:0] cases_i [case_words],
    input  wire logic [31:0] n_cases_i,
    input  wire logic [31:0] sent_i,
    output logic      [31:0] retired_o,
    output logic      [31:0] errors_o,
    output logic      [31:0] tests_ok_o,
    output logic      [31:0] tests_bad_o
);

    int          retired = 0;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          test_entries = 0;
    int          test_errs = 0;
    logic        was_stalled = 1'b0;
    logic [63:0] held_pc;
    logic [4:0]  held_rd;
    logic [63:0] held_data;

    assign retired_o   = retired;
    assign errors_o    = errors;
    assign tests_ok_o  = tests_ok;
    assign tests_bad_o = tests_bad;

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    // ----------------------------------------
    // one retiring result against its row
    // ----------------------------------------
    task automatic retire_entry();
        int   base;
        logic last;
        base = retired * 6;
        if (retired >= n_cases_i) begin
            note_error("a result retired beyond the last instruction in the cases file");
        end else begin
            check_field("wb_pc_o", rv_pipe_pkg::reset_pc + 64'(retired) * 64'd4, wb_pc_i);
            check_field("wb_wen_o", cases_i[base + 2], {63'b0, wb_wen_i});
            check_field("wb_illegal_o", cases_i[base + 3], {63'b0, wb_illegal_i});
            check_field("wb_rd_o", cases_i[base + 4], {59'b0, wb_rd_i});
            if (cases_i[base + 3] == 64'd0) begin
                check_field("wb_data_o", cases_i[base + 5], wb_data_i); // don't care if illegal
            end
            retired++;
            test_entries++;
            last = (retired >= n_cases_i) || (cases_i[base + 6] != cases_i[base]);
            if (last) begin
                $display("test %0d: %0d entries retired, %0d mismatches",
                         cases_i[base], test_entries, test_errs);
                if (test_errs == 0) begin
                    tests_ok++;
                end else begin
                    tests_bad++;
                end
                test_entries = 0;
                test_errs    = 0;
            end
        end
    endtask

    // mid-cycle sampling, inputs change 1 ns after the rising edge
    always @(negedge clk) begin
        if (rst) begin
            was_stalled = 1'b0;
        end else begin
            if (wb_valid_i && retired >= sent_i) begin
                note_error("wb_valid_o is high with no instruction outstanding");
            end
            if (!wb_valid_i && !in_ready_i) begin
                note_error("in_ready_o is low while the execute stage is empty");
            end
            if (was_stalled) begin
                check_field("wb_valid_o (stalled)", 64'd1, {63'b0, wb_valid_i});
                check_field("wb_pc_o (stalled)", held_pc, wb_pc_i);
                check_field("wb_rd_o (stalled)", {59'b0, held_rd}, {59'b0, wb_rd_i});
                check_field("wb_data_o (stalled)", held_data, wb_data_i);
            end
            if (wb_valid_i && wb_ready_i) begin
                retire_entry();     // retires at the coming edge
            end
            was_stalled = wb_valid_i && !wb_ready_i;
            held_pc     = wb_pc_i;
            held_rd     = wb_rd_i;
            held_data   = wb_data_i;
        end
    end

endmodule

`default_nettype wire

//--- testbench/rv_pipe_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_chk (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        in_ready_i,
    input wire logic        wb_valid_i,
    input wire logic        wb_ready_i,
    input wire logic [63:0] wb_pc_i,
    input wire logic [4:0]  wb_rd_i,
    input wire logic [63:0] wb_data_i
);

    // pipeline comes out of reset empty
    a_empty_after_reset: assert property (@(posedge clk) rst |=> !wb_valid_i)
        else $error("wb_valid_o high in the cycle after reset");

    // result held under back-pressure
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        wb_valid_i && !wb_ready_i |=>
            wb_valid_i && $stable(wb_pc_i) && $stable(wb_rd_i) && $stable(wb_data_i))
        else $error("write-back result changed while wb_ready_i was low");

    a_ready_when_empty: assert property (@(posedge clk) disable iff (rst)
        !wb_valid_i |-> in_ready_i)
        else $error("in_ready_o low although execute holds nothing");

endmodule

`default_nettype wire

//--- testbench/tb_rv_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipe;

    localparam int max_cases  = 64;
    localparam int case_words = max_cases * 6;  // six columns per row

    logic        clk;
    logic        rst;
    logic        in_valid_i;
    logic [31:0] in_inst_i;
    logic        in_ready_o;
    logic        wb_ready_i;
    logic        wb_valid_o;
    logic [63:0] wb_pc_o;
    logic        wb_wen_o;
    logic        wb_illegal_o;
    logic [4:0]  wb_rd_o;
    logic [63:0] wb_data_o;

    logic [63:0] cases_mem [case_words];
    int          n_cases = 0;
    int          sent = 0;        // accepted words, also index of the next one
    int          cycles = 0;
    logic        in_fire = 1'b0;
    logic [31:0] rnd = 32'h8b69f109;
    logic [31:0] retired;
    logic [31:0] errors;
    logic [31:0] tests_ok;
    logic [31:0] tests_bad;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv_pipe_top uut (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .in_inst_i    (in_inst_i),
        .in_ready_o   (in_ready_o),
        .wb_ready_i   (wb_ready_i),
        .wb_valid_o   (wb_valid_o),
        .wb_pc_o      (wb_pc_o),
        .wb_wen_o     (wb_wen_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    tb_wb_monitor #(.case_words(case_words)) u_monitor (
        .clk          (clk),
        .rst          (rst),
        .in_ready_i   (in_ready_o),
        .wb_valid_i   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_pc_i      (wb_pc_o),
        .wb_wen_i     (wb_wen_o),
        .wb_illegal_i (wb_illegal_o),
        .wb_rd_i      (wb_rd_o),
        .wb_data_i    (wb_data_o),
        .cases_i      (cases_mem),
        .n_cases_i    (n_cases),
        .sent_i       (sent),
        .retired_o    (retired),
        .errors_o     (errors),
        .tests_ok_o   (tests_ok),
        .tests_bad_o  (tests_bad)
    );

    bind rv_pipe_top rv_pipe_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .in_ready_i (in_ready_o),
        .wb_valid_i (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_pc_i    (wb_pc_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_cases();
        for (int k = 0; k < case_words; k++) begin
            cases_mem[k] = '1;  // all ones marks an unused row
        end
        $readmemh("testbench/rv_pipe_cases.txt", cases_mem);
        while (n_cases < max_cases && cases_mem[n_cases * 6] != '1) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no entries could be read from the cases file");
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : drive
        in_valid_i = 1'b0;
        in_inst_i  = '0;
        wb_ready_i = 1'b0;
        load_cases();
        @(negedge rst);
        wb_ready_i = 1'b1;
        repeat (4) @(posedge clk);      // empty pipeline must stay quiet
        while (retired < n_cases) begin
            @(posedge clk);
            if (in_fire) begin
                sent++;
            end
            #1;
            if (!in_valid_i || in_fire) begin
                rnd = lcg_next(rnd);
                in_valid_i = (sent < n_cases) && (rnd[31:30] != 2'b00); // some gaps
                if (sent < n_cases) begin
                    in_inst_i = cases_mem[sent * 6 + 1][31:0];
                end
            end
            rnd = lcg_next(rnd);
            wb_ready_i = (rnd[31:30] != 2'b00);     // stall about one cycle in four
            #2;
            in_fire = in_valid_i && in_ready_o;
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        wb_ready_i = 1'b1;
        repeat (6) @(posedge clk);      // nothing may retire after the last entry
        $display("summary: %0d tests clean, %0d tests with mismatches, %0d errors",
                 tests_ok, tests_bad, errors);
        if (n_cases > 0 && errors == 0 && tests_bad == 0 && retired == n_cases) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        @(negedge rst);
        limit = n_cases * 8 + 40;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the pipeline stopped retiring at %0d of %0d",
                 cycles, retired, n_cases);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/rv_pipe_cases.txt
// test  inst      wen  illegal  rd  data
// all hex, one instruction per row in program order
1 00500093 1 0 01 5
1 ffd00113 1 0 02 fffffffffffffffd
1 123451b7 1 0 03 12345000
1 80000237 1 0 04 ffffffff80000000
1 0f017293 1 0 05 f0
1 f000e313 1 0 06 ffffffffffffff05
1 fff0c393 1 0 07 fffffffffffffffa
1 00012413 1 0 08 1
1 fff0b493 1 0 09 1
1 7ff13513 1 0 0a 0
2 002085b3 1 0 0b 2
2 40208633 1 0 0c 8
2 002276b3 1 0 0d ffffffff80000000
2 0011e733 1 0 0e 12345005
2 004147b3 1 0 0f 7ffffffd
2 00122833 1 0 10 1
2 001238b3 1 0 11 0
3 06400a13 1 0 14 64
3 014a0a33 1 0 14 c8
3 401a0ab3 1 0 15 c3
3 0ffaca93 1 0 15 3c
3 014afb33 1 0 16 8
4 00109bb3 0 1 17 0
4 0000a283 0 1 05 0
4 00708013 1 0 00 c
4 00500c33 1 0 18 f0
4 0000ecb3 1 0 19 5
4 40100d33 1 0 1a fffffffffffffffb

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_rv_pipe
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
rtl/rv_pipe_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_pipe_top.sv
testbench/tb_clk_gen.sv
testbench/tb_wb_monitor.sv
testbench/rv_pipe_chk.sv
testbench/tb_rv_pipe.sv
